// File: sparse_mul_pkg.sv
// shared constants and types for the sparse polynomial multiplier
// modulus, coefficient and lane sum types, pipeline depth

package sparse_mul_pkg;

  // ------------------------------------------------------------
  // modulus and coefficient format
  // ------------------------------------------------------------

  // reduction relies on 2**COEFF_W - Q = 5
  localparam int Q = 251;

  localparam int COEFF_W = 8;

  typedef logic [COEFF_W-1:0] coeff_t;

  // ------------------------------------------------------------
  // lane summation and pipeline
  // ------------------------------------------------------------

  // upper bound on parallel lanes
  localparam int MAX_CORES = 8;

  // holds MAX_CORES values of at most Q each
  typedef logic [COEFF_W+$clog2(MAX_CORES)-1:0] lane_sum_t;

  // index issue to result write, in cycles
  localparam int PIPE_DEPTH = 7;

endpackage

// File: pass_ctrl_if.sv
// pass and sweep control bundle
// shared by the FSM, the counters, the lanes and the accumulator

`timescale 1ns/1ps

interface pass_ctrl_if
#(
  parameter int IDX_W  = 6,
  parameter int PASS_W = 2
)
();

  // from the FSM
  logic              pass_start;
  logic              pos_load;
  logic              sweep_valid;
  logic              first_pass;

  // from the counters
  logic [IDX_W-1:0]  sweep_idx;
  logic              neg_half;
  logic              sweep_last;
  logic              flush_last;
  logic              pass_last;
  logic [PASS_W-1:0] pass_idx;

  modport fsm (
    output pass_start, pos_load, sweep_valid, first_pass,
    input  sweep_last, flush_last, pass_last
  );

  modport counter (
    input  pass_start, sweep_valid,
    output sweep_idx, neg_half, sweep_last, flush_last, pass_last, pass_idx
  );

  modport lanes (input pos_load, sweep_valid, sweep_idx, neg_half);

  modport accum (input sweep_valid, sweep_idx, first_pass);

endinterface

// File: sparse_ram.sv
// simple dual port RAM, one write and one registered read port
// the word type is a parameter

`timescale 1ns/1ps

module sparse_ram
#(
  parameter int  DEPTH  = 64,
  parameter type word_t = logic [7:0]
)
(
  input  logic                     clk,
  input  logic                     wr_en,
  input  logic [$clog2(DEPTH)-1:0] wr_addr,
  input  word_t                    wr_data,
  input  logic                     rd_en,
  input  logic [$clog2(DEPTH)-1:0] rd_addr,
  output word_t                    rd_data
);

  word_t mem [DEPTH];

  always_ff @(posedge clk)
  begin
    if (wr_en)
      mem[wr_addr] <= wr_data;
    // output holds its last word when not read
    if (rd_en)
      rd_data <= mem[rd_addr];
  end

endmodule

// File: sparse_mul_fsm.sv
// run sequencer: IDLE, then fetch, sweep and flush for every pass
// drives busy, done and the pass control strobes

`timescale 1ns/1ps

module sparse_mul_fsm
(
  input  logic     clk,
  input  logic     arst_n,
  input  logic     start,
  output logic     busy,
  output logic     done,
  pass_ctrl_if.fsm ctl
);

  typedef enum logic [1:0] {IDLE, FETCH, SWEEP, FLUSH} state_t;

  state_t state;
  logic   fetch_cnt;
  logic   pass_end;

  assign pass_end = (state == FLUSH) && ctl.flush_last;

  // pulse on the edge into FETCH so pass_idx is already valid in its first cycle
  assign ctl.pass_start  = ((state == IDLE) && start) || (pass_end && !ctl.pass_last);
  // position word sits on the RAM output in the second fetch cycle
  assign ctl.pos_load    = (state == FETCH) && fetch_cnt;
  assign ctl.sweep_valid = (state == SWEEP);

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state          <= IDLE;
      fetch_cnt      <= 1'b0;
      busy           <= 1'b0;
      done           <= 1'b0;
      ctl.first_pass <= 1'b0;
    end
    else
    begin
      done <= 1'b0;
      case (state)
        IDLE:
        begin
          if (start)
          begin
            state          <= FETCH;
            busy           <= 1'b1;
            ctl.first_pass <= 1'b1;
          end
        end
        FETCH:
        begin
          fetch_cnt <= ~fetch_cnt;
          if (fetch_cnt)
            state <= SWEEP;
        end
        SWEEP:
        begin
          if (ctl.sweep_last)
            state <= FLUSH;
        end
        FLUSH:
        begin
          if (ctl.flush_last)
          begin
            ctl.first_pass <= 1'b0;
            if (ctl.pass_last)
            begin
              state <= IDLE;
              busy  <= 1'b0;
              done  <= 1'b1;
            end
            else
              state <= FETCH;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

// File: sweep_counter.sv
// pass counter, sweep index counter and flush timer
// also flags the negative half of the position list

`timescale 1ns/1ps

module sweep_counter
  import sparse_mul_pkg::*;
#(
  parameter int N        = 64,
  parameter int H        = 16,
  parameter int CORE_NUM = 4
)
(
  input  logic         clk,
  input  logic         arst_n,
  pass_ctrl_if.counter ctl
);

  localparam int IDX_W   = $clog2(N);
  localparam int PASSES  = H / CORE_NUM;
  localparam int PASS_W  = $clog2(PASSES);
  localparam int FLUSH_W = $clog2(PIPE_DEPTH + 1);

  logic [FLUSH_W-1:0] flush_cnt;
  logic               run_on;

  assign ctl.sweep_last = ctl.sweep_valid && (ctl.sweep_idx == IDX_W'(N - 1));
  assign ctl.flush_last = (flush_cnt == FLUSH_W'(PIPE_DEPTH));
  assign ctl.pass_last  = (ctl.pass_idx == PASS_W'(PASSES - 1));
  // positions H/2 and up carry -1
  assign ctl.neg_half   = (int'(ctl.pass_idx) * CORE_NUM) >= (H / 2);

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      ctl.sweep_idx <= '0;
      ctl.pass_idx  <= '0;
      flush_cnt     <= '0;
      run_on        <= 1'b0;
    end
    else
    begin
      if (ctl.sweep_last)
        ctl.sweep_idx <= '0;
      else if (ctl.sweep_valid)
        ctl.sweep_idx <= ctl.sweep_idx + 1'b1;

      // flush timer runs 1..PIPE_DEPTH right after the sweep
      if (ctl.sweep_last)
        flush_cnt <= FLUSH_W'(1);
      else if (ctl.flush_last)
        flush_cnt <= '0;
      else if (flush_cnt != '0)
        flush_cnt <= flush_cnt + 1'b1;

      if (ctl.flush_last && ctl.pass_last)
      begin
        ctl.pass_idx <= '0;
        run_on       <= 1'b0;
      end
      else if (ctl.pass_start)
      begin
        run_on <= 1'b1;
        if (run_on)
          ctl.pass_idx <= ctl.pass_idx + 1'b1;
      end
    end
  end

endmodule

// File: position_lanes.sv
// CORE_NUM lanes, each with its own copy of the dense polynomial
// read address k - p and negacyclic sign correction per lane

`timescale 1ns/1ps

module position_lanes
  import sparse_mul_pkg::*;
#(
  parameter int  N          = 64,
  parameter int  CORE_NUM   = 4,
  parameter type pos_word_t = logic [CORE_NUM-1:0][$clog2(N)-1:0]
)
(
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 poly_wr_en,
  input  logic [$clog2(N)-1:0] poly_wr_addr,
  input  coeff_t               poly_wr_data,
  input  pos_word_t            pos_word,
  pass_ctrl_if.lanes           ctl,
  output coeff_t               lane_vals [CORE_NUM]
);

  localparam int IDX_W = $clog2(N);

  pos_word_t        pos_q;
  logic [IDX_W-1:0] k_d1;

  // positions of the current pass, plus k aligned with the RAM output
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      pos_q <= '0;
      k_d1  <= '0;
    end
    else
    begin
      if (ctl.pos_load)
        pos_q <= pos_word;
      k_d1 <= ctl.sweep_idx;
    end
  end

  for (genvar i = 0; i < CORE_NUM; i++)
  begin : g_lane
    logic [IDX_W-1:0] rd_addr;
    coeff_t           a_val;
    logic             negate;

    // wraps mod N for free since N is a power of two
    assign rd_addr = ctl.sweep_idx - pos_q[i];

    sparse_ram #(
      .DEPTH  (N),
      .word_t (coeff_t)
    ) i_poly_ram (
      .clk     (clk),
      .wr_en   (poly_wr_en),
      .wr_addr (poly_wr_addr),
      .wr_data (poly_wr_data),
      .rd_en   (ctl.sweep_valid),
      .rd_addr (rd_addr),
      .rd_data (a_val)
    );

    // k < p means the term wrapped past x^N, which flips the sign
    assign negate = ctl.neg_half ^ (k_d1 < pos_q[i]);

    // Q - 0 gives Q here, the reduction downstream takes care of it
    always_ff @(posedge clk)
    begin
      lane_vals[i] <= negate ? coeff_t'(Q) - a_val : a_val;
    end
  end

endmodule

// File: mod_q_accumulate.sv
// lane adder tree, modulo Q reduction and result accumulation
// read, add, write back into the result RAM

`timescale 1ns/1ps

module mod_q_accumulate
  import sparse_mul_pkg::*;
#(
  parameter int N        = 64,
  parameter int CORE_NUM = 4
)
(
  input  logic                 clk,
  input  logic                 arst_n,
  input  coeff_t               lane_vals [CORE_NUM],
  pass_ctrl_if.accum           ctl,
  input  logic                 res_rd_en,
  input  logic [$clog2(N)-1:0] res_rd_addr,
  output coeff_t               res_rd_data
);

  localparam int IDX_W = $clog2(N);
  localparam int SUM_W = $bits(lane_sum_t);

  // stage s of these holds the index issued s cycles ago
  logic [PIPE_DEPTH:1] valid_pipe;
  logic [5:1]          first_pipe;
  logic [IDX_W-1:0]    idx_pipe [1:PIPE_DEPTH];

  lane_sum_t        lane_sum;
  lane_sum_t        lane_sum_q;
  logic [COEFF_W:0] fold_q;
  coeff_t           red_q;
  logic [COEFF_W:0] acc_q;
  coeff_t           wr_data;
  coeff_t           ram_rd_data;
  logic             ram_rd_en;
  logic [IDX_W-1:0] ram_rd_addr;

  // one conditional subtract for inputs below 2Q
  function automatic coeff_t sub_q(input logic [COEFF_W:0] v);
    logic [COEFF_W:0] d;
    d = v - (COEFF_W+1)'(Q);
    return (v >= (COEFF_W+1)'(Q)) ? d[COEFF_W-1:0] : v[COEFF_W-1:0];
  endfunction

  // ------------------------------------------------------------
  // control pipeline
  // ------------------------------------------------------------

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      valid_pipe <= '0;
      first_pipe <= '0;
    end
    else
    begin
      valid_pipe <= {valid_pipe[PIPE_DEPTH-1:1], ctl.sweep_valid};
      first_pipe <= {first_pipe[4:1], ctl.first_pass};
    end
  end

  always_ff @(posedge clk)
  begin
    idx_pipe[1] <= ctl.sweep_idx;
    for (int s = 2; s <= PIPE_DEPTH; s++)
      idx_pipe[s] <= idx_pipe[s-1];
  end

  // ------------------------------------------------------------
  // datapath from the lane values in cycle 2
  // ------------------------------------------------------------

  always_comb
  begin
    lane_sum = '0;
    for (int i = 0; i < CORE_NUM; i++)
      lane_sum = lane_sum + lane_sum_t'(lane_vals[i]);
  end

  always_ff @(posedge clk)
  begin
    lane_sum_q <= lane_sum;
    // fold bits 8 and up back in with weight 2**COEFF_W - Q
    fold_q     <= (COEFF_W+1)'(lane_sum_q[COEFF_W-1:0])
                + (COEFF_W+1)'(lane_sum_q[SUM_W-1:COEFF_W]) * (COEFF_W+1)'(2**COEFF_W - Q);
    red_q      <= sub_q(fold_q);
    // result RAM holds stale data before the first pass
    acc_q      <= (COEFF_W+1)'(red_q) + (first_pipe[5] ? (COEFF_W+1)'(0)
                                                       : (COEFF_W+1)'(ram_rd_data));
    wr_data    <= sub_q(acc_q);
  end

  // pipeline owns the read port whenever an index reaches stage 4
  assign ram_rd_en   = valid_pipe[4] | res_rd_en;
  assign ram_rd_addr = valid_pipe[4] ? idx_pipe[4] : res_rd_addr;

  sparse_ram #(
    .DEPTH  (N),
    .word_t (coeff_t)
  ) i_res_ram (
    .clk     (clk),
    .wr_en   (valid_pipe[PIPE_DEPTH]),
    .wr_addr (idx_pipe[PIPE_DEPTH]),
    .wr_data (wr_data),
    .rd_en   (ram_rd_en),
    .rd_addr (ram_rd_addr),
    .rd_data (ram_rd_data)
  );

  assign res_rd_data = ram_rd_data;

endmodule

// File: sparse_mul.sv
// top level of the sparse ternary polynomial multiplier mod x^N+1
// position RAM, control FSM, counters, lanes and accumulator

`timescale 1ns/1ps

module sparse_mul
  import sparse_mul_pkg::*;
#(
  parameter int N        = 64,
  parameter int H        = 16,
  parameter int CORE_NUM = 4
)
(
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          start,
  output logic                          busy,
  output logic                          done,
  input  logic                          poly_wr_en,
  input  logic [$clog2(N)-1:0]          poly_wr_addr,
  input  coeff_t                        poly_wr_data,
  input  logic                          pos_wr_en,
  input  logic [$clog2(H/CORE_NUM)-1:0] pos_wr_addr,
  input  logic [CORE_NUM*$clog2(N)-1:0] pos_wr_data,
  input  logic                          res_rd_en,
  input  logic [$clog2(N)-1:0]          res_rd_addr,
  output coeff_t                        res_rd_data
);

  localparam int IDX_W  = $clog2(N);
  localparam int PASS_W = $clog2(H / CORE_NUM);

  // lane i takes bits [i*IDX_W +: IDX_W] of a position word
  typedef logic [CORE_NUM-1:0][IDX_W-1:0] pos_word_t;

  pos_word_t pos_word;
  coeff_t    lane_vals [CORE_NUM];

  pass_ctrl_if #(.IDX_W(IDX_W), .PASS_W(PASS_W)) ctl ();

  sparse_mul_fsm i_fsm (
    .clk    (clk),
    .arst_n (arst_n),
    .start  (start),
    .busy   (busy),
    .done   (done),
    .ctl    (ctl.fsm)
  );

  sweep_counter #(.N(N), .H(H), .CORE_NUM(CORE_NUM)) i_counter (
    .clk    (clk),
    .arst_n (arst_n),
    .ctl    (ctl.counter)
  );

  sparse_ram #(.DEPTH(H / CORE_NUM), .word_t(pos_word_t)) i_pos_ram (
    .clk     (clk),
    .wr_en   (pos_wr_en),
    .wr_addr (pos_wr_addr),
    .wr_data (pos_wr_data),
    .rd_en   (busy),
    .rd_addr (ctl.pass_idx),
    .rd_data (pos_word)
  );

  position_lanes #(.N(N), .CORE_NUM(CORE_NUM), .pos_word_t(pos_word_t)) i_lanes (
    .clk          (clk),
    .arst_n       (arst_n),
    .poly_wr_en   (poly_wr_en),
    .poly_wr_addr (poly_wr_addr),
    .poly_wr_data (poly_wr_data),
    .pos_word     (pos_word),
    .ctl          (ctl.lanes),
    .lane_vals    (lane_vals)
  );

  mod_q_accumulate #(.N(N), .CORE_NUM(CORE_NUM)) i_accum (
    .clk         (clk),
    .arst_n      (arst_n),
    .lane_vals   (lane_vals),
    .ctl         (ctl.accum),
    .res_rd_en   (res_rd_en),
    .res_rd_addr (res_rd_addr),
    .res_rd_data (res_rd_data)
  );

endmodule

// File: sparse_mul_props.sv
// concurrent checks on the top-level ports of the multiplier
// done pulse width, busy against done, no loads during a run

`timescale 1ns/1ps

module sparse_mul_props
(
  input logic clk,
  input logic arst_n,
  input logic busy,
  input logic done,
  input logic poly_wr_en,
  input logic pos_wr_en
);

  // done is a single cycle pulse
  assert property (@(posedge clk) disable iff (!arst_n) done |=> !done)
    else $error("done held for more than one cycle");

  // busy drops in the same cycle as done
  assert property (@(posedge clk) disable iff (!arst_n) done |-> !busy)
    else $error("busy still high while done is high");

  // host loads are only legal while idle
  assert property (@(posedge clk) disable iff (!arst_n) busy |-> !(poly_wr_en || pos_wr_en))
    else $error("coefficient or position write while busy");

endmodule

bind sparse_mul sparse_mul_props i_props (
  .clk        (clk),
  .arst_n     (arst_n),
  .busy       (busy),
  .done       (done),
  .poly_wr_en (poly_wr_en),
  .pos_wr_en  (pos_wr_en)
);

// File: tb_sparse_mul.sv
// testbench for the sparse ternary polynomial multiplier
// random stimulus, reference model, compare tasks and run timing checks

`timescale 1ns/1ps

module tb_sparse_mul
  import sparse_mul_pkg::*;
();

  localparam int N        = 64;
  localparam int H        = 16;
  localparam int CORE_NUM = 4;
  localparam int IDX_W    = $clog2(N);
  localparam int PASSES   = H / CORE_NUM;
  localparam int EXP_LAT  = PASSES * (2 + N + PIPE_DEPTH) + 1;
  localparam int TIMEOUT  = 2 * 5 * (N + PASSES + 4 * (2 + N + PIPE_DEPTH) + 2 * N);

  logic                          clk;
  logic                          arst_n;
  logic                          start;
  logic                          busy;
  logic                          done;
  logic                          poly_wr_en;
  logic [IDX_W-1:0]              poly_wr_addr;
  coeff_t                        poly_wr_data;
  logic                          pos_wr_en;
  logic [$clog2(PASSES)-1:0]     pos_wr_addr;
  logic [CORE_NUM*IDX_W-1:0]     pos_wr_data;
  logic                          res_rd_en;
  logic [IDX_W-1:0]              res_rd_addr;
  coeff_t                        res_rd_data;

  coeff_t a_poly  [N];
  int     pos_list [H];
  coeff_t exp_res [N];
  int     error_count = 0;
  int     test_count  = 0;
  int     failed_tests = 0;
  int     cycle_count = 0;

  sparse_mul #(.N(N), .H(H), .CORE_NUM(CORE_NUM)) i_sparse_mul (.*);

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // hard limit on the run length
  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT)
    begin
      $display("run did not finish within %0d cycles", TIMEOUT);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // compare tasks
  // ------------------------------------------------------------

  task automatic check_coeff(input coeff_t got, input coeff_t exp, input string what);
    if (got !== exp)
    begin
      $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp)
    begin
      $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_count++;
    if (error_count == errs_before)
      $display("test %0d (%s): ok", test_count, name);
    else
    begin
      failed_tests++;
      $display("test %0d (%s): %0d errors", test_count, name, error_count - errs_before);
    end
  endtask

  // ------------------------------------------------------------
  // stimulus and reference model
  // ------------------------------------------------------------

  task automatic fill_coeffs(input bit corner);
    for (int k = 0; k < N; k++)
    begin
      a_poly[k] = coeff_t'($urandom % Q);
      // zeros and Q-1 sprinkled through the corner case
      if (corner && (k % 8 == 0))
        a_poly[k] = '0;
      if (corner && (k % 8 == 1))
        a_poly[k] = coeff_t'(Q - 1);
    end
  endtask

  task automatic pick_positions(input bit corner);
    bit used [N];
    int p;
    foreach (used[i])
      used[i] = 1'b0;
    if (corner)
    begin
      // N-1 on the + side wraps almost always, 0 on the - side never does
      pos_list[0]     = N - 1;
      pos_list[H / 2] = 0;
      used[N - 1]     = 1'b1;
      used[0]         = 1'b1;
    end
    for (int j = 0; j < H; j++)
    begin
      if (!(corner && (j == 0 || j == H / 2)))
      begin
        p = $urandom % N;
        while (used[p])
          p = (p + 1) % N;
        used[p]     = 1'b1;
        pos_list[j] = p;
      end
    end
  endtask

  // c[k] = sum of +-a[(k-p) mod N], sign flipped on wrap
  function automatic void compute_model();
    int acc;
    int p;
    int term;
    for (int k = 0; k < N; k++)
    begin
      acc = 0;
      for (int j = 0; j < H; j++)
      begin
        p    = pos_list[j];
        term = int'(a_poly[(k - p + N) % N]);
        if ((j >= H / 2) != (k < p))
          acc -= term;
        else
          acc += term;
      end
      acc = acc % Q;
      if (acc < 0)
        acc += Q;
      exp_res[k] = coeff_t'(acc);
    end
  endfunction

  task automatic load_inputs();
    logic [CORE_NUM*IDX_W-1:0] word;
    for (int k = 0; k < N; k++)
    begin
      @(posedge clk);
      poly_wr_en   <= 1'b1;
      poly_wr_addr <= IDX_W'(k);
      poly_wr_data <= a_poly[k];
    end
    @(posedge clk);
    poly_wr_en <= 1'b0;
    for (int w = 0; w < PASSES; w++)
    begin
      for (int i = 0; i < CORE_NUM; i++)
        word[i*IDX_W +: IDX_W] = IDX_W'(pos_list[w * CORE_NUM + i]);
      pos_wr_en   <= 1'b1;
      pos_wr_addr <= w[$clog2(PASSES)-1:0];
      pos_wr_data <= word;
      @(posedge clk);
    end
    pos_wr_en <= 1'b0;
  endtask

  // pulses start and counts cycles until done shows up
  task automatic run_multiply(output int latency);
    logic seen_done;
    latency   = 0;
    seen_done = 1'b0;
    @(posedge clk);
    start <= 1'b1;
    while (!seen_done)
    begin
      @(posedge clk);
      start <= 1'b0;
      latency++;
      @(negedge clk);
      if (done)
        seen_done = 1'b1;
      else
        check_flag(busy, 1'b1, "busy during run");
    end
    check_flag(busy, 1'b0, "busy in the done cycle");
    @(negedge clk);
    check_flag(done, 1'b0, "done one cycle later");
  endtask

  task automatic read_and_check(input string tag);
    for (int k = 0; k < N; k++)
    begin
      @(posedge clk);
      res_rd_en   <= 1'b1;
      res_rd_addr <= IDX_W'(k);
      @(posedge clk);
      res_rd_en <= 1'b0;
      @(negedge clk);
      check_coeff(res_rd_data, exp_res[k], $sformatf("%s c[%0d]", tag, k));
    end
  endtask

  task automatic run_test(input string name, input bit corner, input bit check_time);
    int errs_before;
    int latency;
    errs_before = error_count;
    fill_coeffs(corner);
    pick_positions(corner);
    compute_model();
    load_inputs();
    run_multiply(latency);
    if (check_time)
      check_flag(latency == EXP_LAT, 1'b1,
                 $sformatf("done after %0d cycles (want %0d)", latency, EXP_LAT));
    read_and_check(name);
    report_test(name, errs_before);
  endtask

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------

  initial
  begin
    int errs_before;
    void'($urandom(32'h301e_cb28));
    arst_n       = 1'b0;
    start        = 1'b0;
    poly_wr_en   = 1'b0;
    poly_wr_addr = '0;
    poly_wr_data = '0;
    pos_wr_en    = 1'b0;
    pos_wr_addr  = '0;
    pos_wr_data  = '0;
    res_rd_en    = 1'b0;
    res_rd_addr  = '0;
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;

    errs_before = error_count;
    @(negedge clk);
    check_flag(busy, 1'b0, "busy after reset");
    check_flag(done, 1'b0, "done after reset");
    report_test("reset state", errs_before);

    run_test("random run", 1'b0, 1'b0);
    run_test("second run", 1'b0, 1'b0);
    run_test("corner values", 1'b1, 1'b0);
    run_test("busy and done timing", 1'b0, 1'b1);

    $display("%0d tests, %0d failed, %0d errors", test_count, failed_tests, error_count);
    if (error_count == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// File: sparse_mul.f
sparse_mul_pkg.sv
pass_ctrl_if.sv
sparse_ram.sv
sparse_mul_fsm.sv
sweep_counter.sv
position_lanes.sv
mod_q_accumulate.sv
sparse_mul.sv
sparse_mul_props.sv
tb_sparse_mul.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f sparse_mul.f --top-module tb_sparse_mul -o sim_sparse_mul
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_sparse_mul > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TESTBENCH PASSED" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
